// ==== mc_bridge.f ====
source/mc_bridge_pkg.sv
source/cmd_fifo.sv
source/mc_request_issue.sv
source/trans_tracker.sv
source/mc_bridge.sv
tb/mc_bridge_chk.sv
tb/mc_bridge_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build with Verilator and run the testbench
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module mc_bridge_tb \
  -f mc_bridge.f \
  -o sim_mc_bridge \
  && ./obj_dir/sim_mc_bridge | tee /dev/stderr | grep -qx "RESULT: PASS" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// ==== tb/mc_bridge_tb.sv ====
`timescale 1ns/1ns

module mc_bridge_tb;

  import mc_bridge_pkg::*;

  localparam int num_cmds       = 80;
  localparam int clk_period     = 100;
  localparam int link_credits   = 4;
  localparam int num_tiles_x    = 4;
  localparam int stall_start    = 40;
  localparam int stall_end      = 140;

  logic clk_i = 1'b0;
  logic rst_n_i;
  logic cmd_v_i;
  cmd_type_e cmd_type_i;
  cmd_size_e cmd_size_i;
  logic [31:0] cmd_addr_i;
  logic [31:0] cmd_data_i;
  logic cmd_ready_o;
  logic resp_v_o;
  cmd_type_e resp_type_o;
  cmd_size_e resp_size_o;
  logic [31:0] resp_addr_o;
  logic [31:0] resp_data_o;
  logic resp_yumi_i;
  logic pkt_v_o;
  pkt_op_e pkt_op_o;
  logic [15:0] pkt_addr_o;
  logic [3:0] pkt_x_o;
  logic [3:0] pkt_y_o;
  logic [3:0] pkt_src_x_o;
  logic [3:0] pkt_src_y_o;
  logic [3:0] pkt_mask_o;
  logic [4:0] pkt_reg_id_o;
  pkt_payload_u pkt_payload_o;
  logic ret_v_i;
  logic [4:0] ret_reg_id_i;
  logic [31:0] ret_data_i;
  logic [3:0] my_x_i;
  logic [3:0] my_y_i;

  // stimulus and expected values with one entry per command
  cmd_type_e c_type [num_cmds];
  cmd_size_e c_size [num_cmds];
  logic [31:0] c_addr [num_cmds];
  logic [31:0] c_data [num_cmds];
  pkt_op_e e_op [num_cmds];
  logic [3:0] e_x [num_cmds];
  logic [3:0] e_y [num_cmds];
  logic [15:0] e_epa [num_cmds];
  logic [3:0] e_mask [num_cmds];
  pkt_payload_u e_pay [num_cmds];
  logic [31:0] e_rdata [num_cmds];

  logic [31:0] ref_mem [logic [23:0]];
  logic [31:0] net_mem [logic [23:0]];
  int pend_due [$];
  logic [4:0] pend_id [$];
  logic [31:0] pend_data [$];

  logic [31:0] seed = 32'd25;
  int errors = 0;
  int cycle = 0;
  int pkt_count = 0;
  int resp_count = 0;
  int outstanding = 0;
  logic running = 1'b0;
  logic saw_not_ready = 1'b0;

  mc_bridge i_mc_bridge (.*);

  always #(clk_period / 2) clk_i = ~clk_i;

  function automatic int next_rand(input int n);
    seed = seed * 32'd1103515245 + 32'd12345;
    return int'(seed[30:16]) % n;
  endfunction

  // untouched words read back a pattern built from the whole key
  function automatic logic [31:0] fill_word(input logic [23:0] key);
    return {8'ha5, key ^ 24'h3c5a96};
  endfunction

  function automatic logic [31:0] merge_word(input logic [31:0] old, data,
                                             input logic [3:0] mask);
    logic [31:0] bm;
    bm = {{8{mask[3]}}, {8{mask[2]}}, {8{mask[1]}}, {8{mask[0]}}};
    return (old & ~bm) | (data & bm);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // reference model of the packet encoding
  ////////////////////////////////////////////////////////////////////////////
  function automatic void ref_packet(input cmd_type_e t, input cmd_size_e s,
                                     input logic [31:0] a, d, output pkt_op_e op,
                                     output logic [3:0] x, y, output logic [15:0] epa,
                                     output logic [3:0] mask, output pkt_payload_u pay);
    logic [31:0] word;
    logic [3:0] base;
    word = (a - 32'h4000_0000) >> 2;
    if (a[31])
    begin
      x = a[27:24];
      y = a[23:20];
      epa = a[17:2];
    end
    else if (a >= 32'h4000_0000)
    begin
      x = 4'((word / 32'd8) % 32'(num_tiles_x));
      y = 4'd8;
      epa = word[15:0];
    end
    else
    begin
      x = 4'd0;
      y = 4'd0;
      epa = a[17:2];
    end
    base = (s == size_byte) ? 4'h1 : (s == size_half) ? 4'h3 : 4'hf;
    mask = base << a[1:0];
    pay = '0;
    if (t == cmd_read)
    begin
      op = op_remote_load;
      pay.load.info.is_byte = (s == size_byte);
      pay.load.info.is_hex = (s == size_half);
      pay.load.info.part_sel = a[1:0];
    end
    else
    begin
      op = (s == size_word) ? op_remote_store : op_masked_store;
      pay.store_data = d;
    end
  endfunction

  task automatic stop_on_error(input string msg);
    errors++;
    $display("%s", msg);
    $display("RESULT: FAIL");
    $fatal(1, "stopping at first error");
  endtask

  task automatic compare_word(input string name, input logic [31:0] got, exp);
    if (got !== exp)
      stop_on_error($sformatf("FAIL t=%0t %s got=%h exp=%h", $time, name, got, exp));
  endtask

  task automatic check_packet(input int n, input pkt_op_e op, input pkt_payload_u pay);
    if (pkt_op_o !== op)
      stop_on_error($sformatf("FAIL t=%0t pkt_op_o got=%s exp=%s", $time,
                              pkt_op_o.name(), op.name()));
    compare_word("pkt_payload_o", pkt_payload_o, pay);
    compare_word("pkt_x_o", 32'(pkt_x_o), 32'(e_x[n]));
    compare_word("pkt_y_o", 32'(pkt_y_o), 32'(e_y[n]));
    compare_word("pkt_addr_o", 32'(pkt_addr_o), 32'(e_epa[n]));
    compare_word("pkt_reg_id_o", 32'(pkt_reg_id_o), 32'(n % 8));
    compare_word("pkt_src_x_o", 32'(pkt_src_x_o), 32'(my_x_i));
    compare_word("pkt_src_y_o", 32'(pkt_src_y_o), 32'(my_y_i));
    if (c_type[n] == cmd_write)
      compare_word("pkt_mask_o", 32'(pkt_mask_o), 32'(e_mask[n]));
  endtask

  task automatic check_resp(input cmd_type_e t, input cmd_size_e s,
                            input logic [31:0] a, input logic [31:0] rdata);
    if (resp_type_o !== t)
      stop_on_error($sformatf("FAIL t=%0t resp_type_o got=%s exp=%s", $time,
                              resp_type_o.name(), t.name()));
    if (resp_size_o !== s)
      stop_on_error($sformatf("FAIL t=%0t resp_size_o got=%s exp=%s", $time,
                              resp_size_o.name(), s.name()));
    compare_word("resp_addr_o", resp_addr_o, a);
    if (t == cmd_read)
      compare_word("resp_data_o", resp_data_o, rdata);
  endtask

  task automatic check_credits(input int in_flight);
    if (in_flight > link_credits)
      stop_on_error($sformatf("packet sent at t=%0t with %0d packets already in flight",
                              $time, in_flight - 1));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // command generation and driver
  ////////////////////////////////////////////////////////////////////////////
  initial
  begin
    int i;
    int off;
    logic [1:0] low;
    logic [23:0] key;
    logic go;
    init_inputs();
    for (i = 0; i < num_cmds; i++)
    begin
      c_type[i] = cmd_type_e'(next_rand(2) == 1);
      c_size[i] = cmd_size_e'(next_rand(3));
      low = (c_size[i] == size_byte) ? 2'(next_rand(4)) :
            (c_size[i] == size_half) ? 2'(next_rand(2) * 2) : 2'd0;
      off = next_rand(16);
      case (next_rand(3))
        0: c_addr[i] = {1'b1, 3'b0, 4'(next_rand(4)), 4'(next_rand(4)), 2'b0, 16'(off), low};
        1: c_addr[i] = 32'h4000_0000 + 32'(next_rand(64) * 4) + 32'(low);
        default: c_addr[i] = 32'(off * 4) + 32'(low);
      endcase
      c_data[i] = {16'(next_rand(65536)), 16'(next_rand(65536))};
      ref_packet(c_type[i], c_size[i], c_addr[i], c_data[i], e_op[i], e_x[i], e_y[i],
                 e_epa[i], e_mask[i], e_pay[i]);
      key = {e_x[i], e_y[i], e_epa[i]};
      if (!ref_mem.exists(key))
        ref_mem[key] = fill_word(key);
      e_rdata[i] = ref_mem[key];
      if (c_type[i] == cmd_write)
        ref_mem[key] = merge_word(ref_mem[key], c_data[i], e_mask[i]);
    end
    repeat (4) @(posedge clk_i);
    running = 1'b1;
    @(negedge clk_i);
    rst_n_i = 1'b1;
    if (pkt_v_o !== 1'b0 || resp_v_o !== 1'b0 || cmd_ready_o !== 1'b1)
      stop_on_error("outputs after reset are not idle with the queue ready");
    i = 0;
    while (i < num_cmds)
    begin
      // valid is drawn away from the falling edge where the network model draws
      @(posedge clk_i);
      go = (next_rand(4) != 0);
      @(negedge clk_i);
      cmd_v_i = go;
      cmd_type_i = c_type[i];
      cmd_size_i = c_size[i];
      cmd_addr_i = c_addr[i];
      cmd_data_i = c_data[i];
      if (cmd_v_i && cmd_ready_o)
        i++;
    end
    @(negedge clk_i);
    cmd_v_i = 1'b0;
    wait (resp_count == num_cmds);
    @(negedge clk_i);
    if (outstanding != 0)
      stop_on_error("packets still in flight after the last response");
    if (!saw_not_ready)
      stop_on_error("cmd_ready_o never fell while responses were held");
    if (errors == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

  task automatic init_inputs();
    rst_n_i = 1'b0;
    cmd_v_i = 1'b0;
    cmd_type_i = cmd_read;
    cmd_size_i = size_word;
    cmd_addr_i = '0;
    cmd_data_i = '0;
    resp_yumi_i = 1'b0;
    ret_v_i = 1'b0;
    ret_reg_id_i = '0;
    ret_data_i = '0;
    my_x_i = 4'd3;
    my_y_i = 4'd5;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // network model and response side
  ////////////////////////////////////////////////////////////////////////////
  always @(negedge clk_i)
  begin
    logic [23:0] key;
    logic [31:0] rdata;
    int ready_n;
    int pick;
    int k;
    if (running)
    begin
      cycle++;
      if (pkt_v_o)
      begin
        check_packet(pkt_count, e_op[pkt_count], e_pay[pkt_count]);
        key = {pkt_x_o, pkt_y_o, pkt_addr_o};
        rdata = net_mem.exists(key) ? net_mem[key] : fill_word(key);
        if (pkt_op_o != op_remote_load)
          net_mem[key] = merge_word(rdata, pkt_payload_o.store_data, pkt_mask_o);
        pend_due.push_back(cycle + 1 + next_rand(12));
        pend_id.push_back(pkt_reg_id_o);
        pend_data.push_back((pkt_op_o == op_remote_load) ? rdata : 32'hdead_0000);
        outstanding++;
        check_credits(outstanding);
        pkt_count++;
      end
      // returns leave in shuffled order among the due ones
      ret_v_i = 1'b0;
      ready_n = 0;
      foreach (pend_due[j])
        if (pend_due[j] <= cycle)
          ready_n++;
      if (ready_n != 0)
      begin
        pick = next_rand(ready_n);
        k = 0;
        while (pend_due[k] > cycle || pick != 0)
        begin
          if (pend_due[k] <= cycle)
            pick--;
          k++;
        end
        ret_v_i = 1'b1;
        ret_reg_id_i = pend_id[k];
        ret_data_i = pend_data[k];
        pend_due.delete(k);
        pend_id.delete(k);
        pend_data.delete(k);
        outstanding--;
      end
      resp_yumi_i = 1'b0;
      if (cycle >= stall_start && cycle < stall_end)
      begin
        if (!cmd_ready_o)
          saw_not_ready = 1'b1;
        if (resp_v_o)
          check_resp(c_type[resp_count], c_size[resp_count], c_addr[resp_count],
                     e_rdata[resp_count]);
      end
      else if (resp_v_o)
      begin
        check_resp(c_type[resp_count], c_size[resp_count], c_addr[resp_count],
                   e_rdata[resp_count]);
        resp_yumi_i = 1'b1;
        resp_count++;
      end
    end
  end

  // watchdog
  initial
  begin
    #(longint'(num_cmds) * 200 * clk_period);
    $display("timeout with %0d of %0d responses seen", resp_count, num_cmds);
    $display("RESULT: FAIL");
    $fatal(1, "watchdog expired");
  end

endmodule

// ==== tb/mc_bridge_chk.sv ====
`timescale 1ns/1ns

module mc_bridge_chk
  (input          clk_i
   , input        rst_n_i
   , input        pkt_v_o
   , input        resp_v_o
   , input        resp_type_o
   , input [1:0]  resp_size_o
   , input [31:0] resp_addr_o
   , input [31:0] resp_data_o
   , input        resp_yumi_i
   );

  // no packet leaves while the bridge is held in reset
  pkt_quiet_in_reset: assert property (@(posedge clk_i) !rst_n_i |-> !pkt_v_o)
    else $error("pkt_v_o high during reset");

  // a pending response holds until it is taken
  resp_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (resp_v_o && !resp_yumi_i) |=> (resp_v_o && $stable(resp_type_o)
      && $stable(resp_size_o) && $stable(resp_addr_o) && $stable(resp_data_o)))
    else $error("response changed before yumi");

  yumi_needs_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    resp_yumi_i |-> resp_v_o)
    else $error("resp_yumi_i without resp_v_o");

endmodule

bind mc_bridge mc_bridge_chk i_mc_bridge_chk
  (.clk_i(clk_i), .rst_n_i(rst_n_i), .pkt_v_o(pkt_v_o), .resp_v_o(resp_v_o)
   , .resp_type_o(resp_type_o), .resp_size_o(resp_size_o), .resp_addr_o(resp_addr_o)
   , .resp_data_o(resp_data_o), .resp_yumi_i(resp_yumi_i));

// ==== source/mc_bridge.sv ====
`timescale 1ns/1ns

module mc_bridge
  #(parameter int cmd_depth_p         = 2
    , parameter int max_outstanding_p = 8
    , parameter int link_credits_p    = 4
    , parameter int num_tiles_x_p     = 4
    )
  (input                                             clk_i
   , input                                           rst_n_i

   // processor commands
   , input                                           cmd_v_i
   , input mc_bridge_pkg::cmd_type_e                 cmd_type_i
   , input mc_bridge_pkg::cmd_size_e                 cmd_size_i
   , input [mc_bridge_pkg::paddr_width-1:0]          cmd_addr_i
   , input [mc_bridge_pkg::data_width-1:0]           cmd_data_i
   , output logic                                    cmd_ready_o

   // processor responses
   , output logic                                    resp_v_o
   , output mc_bridge_pkg::cmd_type_e                resp_type_o
   , output mc_bridge_pkg::cmd_size_e                resp_size_o
   , output logic [mc_bridge_pkg::paddr_width-1:0]   resp_addr_o
   , output logic [mc_bridge_pkg::data_width-1:0]    resp_data_o
   , input                                           resp_yumi_i

   // packets to the mesh
   , output logic                                    pkt_v_o
   , output mc_bridge_pkg::pkt_op_e                  pkt_op_o
   , output logic [mc_bridge_pkg::epa_width-1:0]     pkt_addr_o
   , output logic [mc_bridge_pkg::x_cord_width-1:0]  pkt_x_o
   , output logic [mc_bridge_pkg::y_cord_width-1:0]  pkt_y_o
   , output logic [mc_bridge_pkg::x_cord_width-1:0]  pkt_src_x_o
   , output logic [mc_bridge_pkg::y_cord_width-1:0]  pkt_src_y_o
   , output logic [mc_bridge_pkg::mask_width-1:0]    pkt_mask_o
   , output logic [mc_bridge_pkg::reg_id_width-1:0]  pkt_reg_id_o
   , output mc_bridge_pkg::pkt_payload_u             pkt_payload_o

   // returns from the mesh
   , input                                           ret_v_i
   , input [mc_bridge_pkg::reg_id_width-1:0]         ret_reg_id_i
   , input [mc_bridge_pkg::data_width-1:0]           ret_data_i

   , input [mc_bridge_pkg::x_cord_width-1:0]         my_x_i
   , input [mc_bridge_pkg::y_cord_width-1:0]         my_y_i
   );

  import mc_bridge_pkg::*;

  localparam int id_width_lp = $clog2(max_outstanding_p);

  logic                   head_v;
  cmd_type_e              head_type;
  cmd_size_e              head_size;
  logic [paddr_width-1:0] head_addr;
  logic [data_width-1:0]  head_data;
  logic                   head_yumi;

  logic                   alloc_v;
  logic [id_width_lp-1:0] alloc_id;
  logic                   alloc_yumi;

  cmd_fifo
   #(.cmd_depth_p(cmd_depth_p))
   i_cmd_fifo
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)
     ,.in_v_i(cmd_v_i)
     ,.in_ready_o(cmd_ready_o)
     ,.in_type_i(cmd_type_i)
     ,.in_size_i(cmd_size_i)
     ,.in_addr_i(cmd_addr_i)
     ,.in_data_i(cmd_data_i)
     ,.out_v_o(head_v)
     ,.out_type_o(head_type)
     ,.out_size_o(head_size)
     ,.out_addr_o(head_addr)
     ,.out_data_o(head_data)
     ,.out_yumi_i(head_yumi)
     );

  // every return gives one link credit back
  mc_request_issue
   #(.max_outstanding_p(max_outstanding_p)
     ,.link_credits_p(link_credits_p)
     ,.num_tiles_x_p(num_tiles_x_p)
     )
   i_mc_request_issue
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)
     ,.head_v_i(head_v)
     ,.head_type_i(head_type)
     ,.head_size_i(head_size)
     ,.head_addr_i(head_addr)
     ,.head_data_i(head_data)
     ,.head_yumi_o(head_yumi)
     ,.alloc_v_i(alloc_v)
     ,.alloc_id_i(alloc_id)
     ,.alloc_yumi_o(alloc_yumi)
     ,.my_x_i(my_x_i)
     ,.my_y_i(my_y_i)
     ,.credit_return_i(ret_v_i)
     ,.pkt_v_o(pkt_v_o)
     ,.pkt_op_o(pkt_op_o)
     ,.pkt_addr_o(pkt_addr_o)
     ,.pkt_x_o(pkt_x_o)
     ,.pkt_y_o(pkt_y_o)
     ,.pkt_src_x_o(pkt_src_x_o)
     ,.pkt_src_y_o(pkt_src_y_o)
     ,.pkt_mask_o(pkt_mask_o)
     ,.pkt_reg_id_o(pkt_reg_id_o)
     ,.pkt_payload_o(pkt_payload_o)
     );

  trans_tracker
   #(.max_outstanding_p(max_outstanding_p))
   i_trans_tracker
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)
     ,.alloc_v_o(alloc_v)
     ,.alloc_id_o(alloc_id)
     ,.alloc_yumi_i(alloc_yumi)
     ,.hdr_type_i(head_type)
     ,.hdr_size_i(head_size)
     ,.hdr_addr_i(head_addr)
     ,.ret_v_i(ret_v_i)
     ,.ret_reg_id_i(ret_reg_id_i)
     ,.ret_data_i(ret_data_i)
     ,.resp_v_o(resp_v_o)
     ,.resp_type_o(resp_type_o)
     ,.resp_size_o(resp_size_o)
     ,.resp_addr_o(resp_addr_o)
     ,.resp_data_o(resp_data_o)
     ,.resp_yumi_i(resp_yumi_i)
     );

endmodule

// ==== source/trans_tracker.sv ====
`timescale 1ns/1ns

module trans_tracker
  #(parameter int max_outstanding_p = 8
    , localparam int id_width_lp    = $clog2(max_outstanding_p)
    )
  (input                                             clk_i
   , input                                           rst_n_i

   // id allocation with the header saved on yumi
   , output logic                                    alloc_v_o
   , output logic [id_width_lp-1:0]                  alloc_id_o
   , input                                           alloc_yumi_i
   , input mc_bridge_pkg::cmd_type_e                 hdr_type_i
   , input mc_bridge_pkg::cmd_size_e                 hdr_size_i
   , input [mc_bridge_pkg::paddr_width-1:0]          hdr_addr_i

   // network return
   , input                                           ret_v_i
   , input [mc_bridge_pkg::reg_id_width-1:0]         ret_reg_id_i
   , input [mc_bridge_pkg::data_width-1:0]           ret_data_i

   // processor response
   , output logic                                    resp_v_o
   , output mc_bridge_pkg::cmd_type_e                resp_type_o
   , output mc_bridge_pkg::cmd_size_e                resp_size_o
   , output logic [mc_bridge_pkg::paddr_width-1:0]   resp_addr_o
   , output logic [mc_bridge_pkg::data_width-1:0]    resp_data_o
   , input                                           resp_yumi_i
   );

  import mc_bridge_pkg::*;

  localparam int count_width_lp = $clog2(max_outstanding_p + 1);

  cmd_type_e              type_mem [max_outstanding_p];
  cmd_size_e              size_mem [max_outstanding_p];
  logic [paddr_width-1:0] addr_mem [max_outstanding_p];
  logic [data_width-1:0]  data_mem [max_outstanding_p];

  logic [max_outstanding_p-1:0] done_r;
  logic [id_width_lp-1:0]       wr_ptr_r;
  logic [id_width_lp-1:0]       rd_ptr_r;
  logic [count_width_lp-1:0]    count_r;
  logic [id_width_lp-1:0]       ret_id;

  function automatic logic [id_width_lp-1:0] next_id(input logic [id_width_lp-1:0] id);
    if (id == id_width_lp'(max_outstanding_p - 1))
      return '0;
    return id + 1'b1;
  endfunction

  // the tag field is wider than the id space
  assign ret_id = ret_reg_id_i[id_width_lp-1:0];

  assign alloc_v_o  = (count_r != count_width_lp'(max_outstanding_p));
  assign alloc_id_o = wr_ptr_r;

  ////////////////////////////////////////////////////////////////////////////
  // in-order response from the oldest slot
  ////////////////////////////////////////////////////////////////////////////
  assign resp_v_o    = (count_r != '0) & done_r[rd_ptr_r];
  assign resp_type_o = type_mem[rd_ptr_r];
  assign resp_size_o = size_mem[rd_ptr_r];
  assign resp_addr_o = addr_mem[rd_ptr_r];

  // stores return no data
  assign resp_data_o = (type_mem[rd_ptr_r] == cmd_write) ? '0 : data_mem[rd_ptr_r];

  always_ff @(posedge clk_i)
  begin
    if (alloc_yumi_i)
    begin
      type_mem[wr_ptr_r] <= hdr_type_i;
      size_mem[wr_ptr_r] <= hdr_size_i;
      addr_mem[wr_ptr_r] <= hdr_addr_i;
    end
    if (ret_v_i)
      data_mem[ret_id] <= ret_data_i;
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      done_r   <= '0;
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end
    else
    begin
      if (alloc_yumi_i)
        wr_ptr_r <= next_id(wr_ptr_r);

      // a slot is done on its return and free again on yumi
      if (ret_v_i)
        done_r[ret_id] <= 1'b1;
      if (resp_yumi_i)
      begin
        done_r[rd_ptr_r] <= 1'b0;
        rd_ptr_r         <= next_id(rd_ptr_r);
      end

      case ({alloc_yumi_i, resp_yumi_i})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r;
      endcase
    end
  end

endmodule

// ==== source/mc_request_issue.sv ====
`timescale 1ns/1ns

module mc_request_issue
  #(parameter int max_outstanding_p = 8
    , parameter int link_credits_p  = 4
    , parameter int num_tiles_x_p   = 4
    , localparam int id_width_lp    = $clog2(max_outstanding_p)
    )
  (input                                             clk_i
   , input                                           rst_n_i

   // head of the command queue
   , input                                           head_v_i
   , input mc_bridge_pkg::cmd_type_e                 head_type_i
   , input mc_bridge_pkg::cmd_size_e                 head_size_i
   , input [mc_bridge_pkg::paddr_width-1:0]          head_addr_i
   , input [mc_bridge_pkg::data_width-1:0]           head_data_i
   , output logic                                    head_yumi_o

   // transaction id from the tracker
   , input                                           alloc_v_i
   , input [id_width_lp-1:0]                         alloc_id_i
   , output logic                                    alloc_yumi_o

   , input [mc_bridge_pkg::x_cord_width-1:0]         my_x_i
   , input [mc_bridge_pkg::y_cord_width-1:0]         my_y_i
   , input                                           credit_return_i

   , output logic                                    pkt_v_o
   , output mc_bridge_pkg::pkt_op_e                  pkt_op_o
   , output logic [mc_bridge_pkg::epa_width-1:0]     pkt_addr_o
   , output logic [mc_bridge_pkg::x_cord_width-1:0]  pkt_x_o
   , output logic [mc_bridge_pkg::y_cord_width-1:0]  pkt_y_o
   , output logic [mc_bridge_pkg::x_cord_width-1:0]  pkt_src_x_o
   , output logic [mc_bridge_pkg::y_cord_width-1:0]  pkt_src_y_o
   , output logic [mc_bridge_pkg::mask_width-1:0]    pkt_mask_o
   , output logic [mc_bridge_pkg::reg_id_width-1:0]  pkt_reg_id_o
   , output mc_bridge_pkg::pkt_payload_u             pkt_payload_o
   );

  import mc_bridge_pkg::*;

  localparam int credit_width_lp = $clog2(link_credits_p + 1);
  localparam int word_width_lp   = paddr_width - 2;

  logic [credit_width_lp-1:0] credits_r;
  logic                       issue;

  logic                     is_mesh;
  logic                     is_dram;
  logic [paddr_width-1:0]   dram_off;
  logic [word_width_lp-1:0] dram_word;
  logic [word_width_lp-1:0] dram_block;

  logic [x_cord_width-1:0] dst_x;
  logic [y_cord_width-1:0] dst_y;
  logic [epa_width-1:0]    dst_epa;
  logic [mask_width-1:0]   mask;
  pkt_op_e                 op;
  pkt_payload_u            payload;

  ////////////////////////////////////////////////////////////////////////////
  // region decode
  ////////////////////////////////////////////////////////////////////////////
  assign is_mesh = head_addr_i[paddr_width-1];
  assign is_dram = !is_mesh && (head_addr_i >= dram_base_addr);

  // simple hash of the block index modulo the tiles in a row
  assign dram_off   = head_addr_i - dram_base_addr;
  assign dram_word  = dram_off[paddr_width-1:2];
  assign dram_block = dram_word / word_width_lp'(block_words);

  always_comb
  begin
    if (is_mesh)
    begin
      dst_x   = head_addr_i[27:24];
      dst_y   = head_addr_i[23:20];
      dst_epa = head_addr_i[17:2];
    end
    else if (is_dram)
    begin
      dst_x   = x_cord_width'(dram_block % word_width_lp'(num_tiles_x_p));
      dst_y   = y_cord_width'(dram_row);
      dst_epa = dram_word[epa_width-1:0];
    end
    else
    begin
      // host sits at 0,0
      dst_x   = '0;
      dst_y   = '0;
      dst_epa = head_addr_i[17:2];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // packet encoding
  ////////////////////////////////////////////////////////////////////////////
  always_comb
  begin
    case (head_size_i)
      size_byte: mask = mask_width'(4'h1) << head_addr_i[1:0];
      size_half: mask = mask_width'(4'h3) << head_addr_i[1:0];
      default:   mask = mask_width'(4'hf) << head_addr_i[1:0];
    endcase
  end

  always_comb
  begin
    payload = '0;
    if (head_type_i == cmd_read)
    begin
      op                          = op_remote_load;
      payload.load.info.is_byte  = (head_size_i == size_byte);
      payload.load.info.is_hex   = (head_size_i == size_half);
      payload.load.info.part_sel = head_addr_i[1:0];
    end
    else if (head_size_i == size_word)
    begin
      op                 = op_remote_store;
      payload.store_data = head_data_i;
    end
    else
    begin
      op                 = op_masked_store;
      payload.store_data = head_data_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // issue and link credits
  ////////////////////////////////////////////////////////////////////////////
  assign issue        = head_v_i & alloc_v_i & (credits_r != '0);
  assign head_yumi_o  = issue;
  assign alloc_yumi_o = issue;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      credits_r <= credit_width_lp'(link_credits_p);
      pkt_v_o   <= 1'b0;
    end
    else
    begin
      pkt_v_o <= issue;
      case ({issue, credit_return_i})
        2'b10:   credits_r <= credits_r - 1'b1;
        2'b01:   credits_r <= credits_r + 1'b1;
        default: credits_r <= credits_r;
      endcase
    end
  end

  // packet fields held between sends
  always_ff @(posedge clk_i)
  begin
    if (issue)
    begin
      pkt_op_o      <= op;
      pkt_addr_o    <= dst_epa;
      pkt_x_o       <= dst_x;
      pkt_y_o       <= dst_y;
      pkt_src_x_o   <= my_x_i;
      pkt_src_y_o   <= my_y_i;
      pkt_mask_o    <= mask;
      pkt_reg_id_o  <= reg_id_width'(alloc_id_i);
      pkt_payload_o <= payload;
    end
  end

endmodule

// ==== source/cmd_fifo.sv ====
`timescale 1ns/1ns

module cmd_fifo
  #(parameter int cmd_depth_p = 2)
  (input                                          clk_i
   , input                                        rst_n_i

   , input                                        in_v_i
   , output logic                                 in_ready_o
   , input mc_bridge_pkg::cmd_type_e              in_type_i
   , input mc_bridge_pkg::cmd_size_e              in_size_i
   , input [mc_bridge_pkg::paddr_width-1:0]       in_addr_i
   , input [mc_bridge_pkg::data_width-1:0]        in_data_i

   , output logic                                 out_v_o
   , output mc_bridge_pkg::cmd_type_e             out_type_o
   , output mc_bridge_pkg::cmd_size_e             out_size_o
   , output logic [mc_bridge_pkg::paddr_width-1:0] out_addr_o
   , output logic [mc_bridge_pkg::data_width-1:0]  out_data_o
   , input                                        out_yumi_i
   );

  import mc_bridge_pkg::*;

  localparam int ptr_width_lp   = (cmd_depth_p > 1) ? $clog2(cmd_depth_p) : 1;
  localparam int count_width_lp = $clog2(cmd_depth_p + 1);

  cmd_type_e             type_mem [cmd_depth_p];
  cmd_size_e             size_mem [cmd_depth_p];
  logic [paddr_width-1:0] addr_mem [cmd_depth_p];
  logic [data_width-1:0]  data_mem [cmd_depth_p];

  logic [ptr_width_lp-1:0]   wr_ptr_r;
  logic [ptr_width_lp-1:0]   rd_ptr_r;
  logic [count_width_lp-1:0] count_r;
  logic                      enq;

  // wrap at the depth, which need not be a power of two
  function automatic logic [ptr_width_lp-1:0] next_ptr(input logic [ptr_width_lp-1:0] ptr);
    if (ptr == ptr_width_lp'(cmd_depth_p - 1))
      return '0;
    return ptr + 1'b1;
  endfunction

  assign in_ready_o = (count_r != count_width_lp'(cmd_depth_p));
  assign out_v_o    = (count_r != '0);
  assign enq        = in_v_i & in_ready_o;

  assign out_type_o = type_mem[rd_ptr_r];
  assign out_size_o = size_mem[rd_ptr_r];
  assign out_addr_o = addr_mem[rd_ptr_r];
  assign out_data_o = data_mem[rd_ptr_r];

  always_ff @(posedge clk_i)
  begin
    if (enq)
    begin
      type_mem[wr_ptr_r] <= in_type_i;
      size_mem[wr_ptr_r] <= in_size_i;
      addr_mem[wr_ptr_r] <= in_addr_i;
      data_mem[wr_ptr_r] <= in_data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end
    else
    begin
      if (enq)
        wr_ptr_r <= next_ptr(wr_ptr_r);
      if (out_yumi_i)
        rd_ptr_r <= next_ptr(rd_ptr_r);
      case ({enq, out_yumi_i})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r;
      endcase
    end
  end

endmodule

// ==== source/mc_bridge_pkg.sv ====
package mc_bridge_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////////////////////
  localparam int paddr_width  = 32;
  localparam int data_width   = 32;
  localparam int mask_width   = data_width / 8;
  localparam int reg_id_width = 5;
  localparam int x_cord_width = 4;
  localparam int y_cord_width = 4;
  localparam int epa_width    = 16;

  ////////////////////////////////////////////////////////////////////////////
  // address map
  ////////////////////////////////////////////////////////////////////////////
  // bit 31 set selects a mesh tile; below it, dram starts here
  localparam logic [paddr_width-1:0] dram_base_addr = 32'h4000_0000;

  // row of the dram caches in the mesh
  localparam int dram_row    = 8;
  localparam int block_words = 8;

  ////////////////////////////////////////////////////////////////////////////
  // command and packet encodings
  ////////////////////////////////////////////////////////////////////////////
  typedef enum logic
  {
    cmd_read  = 1'b0,
    cmd_write = 1'b1
  } cmd_type_e;

  typedef enum logic [1:0]
  {
    size_byte = 2'd0,
    size_half = 2'd1,
    size_word = 2'd2
  } cmd_size_e;

  typedef enum logic [1:0]
  {
    op_remote_load  = 2'd0,
    op_remote_store = 2'd1,
    op_masked_store = 2'd2
  } pkt_op_e;

  typedef struct packed
  {
    logic       is_byte;
    logic       is_hex;
    logic [1:0] part_sel;
  } load_info_s;

  // load info sits in the low bits, rest of the word is zero
  typedef struct packed
  {
    logic [data_width-$bits(load_info_s)-1:0] pad;
    load_info_s                               info;
  } load_view_s;

  typedef union packed
  {
    logic [data_width-1:0] store_data;
    load_view_s            load;
  } pkt_payload_u;

endpackage
